// File: Makefile
VERILATOR  ?= verilator
TOP        := sound_out_tb
FILE_LIST  := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
src/sound_pkg.sv
src/dac_clock_divider.sv
src/dac_1bit.sv
src/dac_i2s.sv
src/sound_out_top.sv
verification/dac_i2s_assertions.sv
verification/sound_out_tb.sv

// File: src/dac_1bit.sv
`default_nettype none

module dac_1bit
    import sound_pkg::*;
(
    input  logic    DAC_BCLK_SRC,
    input  logic    RESET_n,
    input  logic    clk_en,
    input  sample_t sample,
    output logic    sound_int
);

    // Offset-binary form of the sample
    logic [sample_width-1:0] offset;

    // Accumulator register and its next value
    pdm_acc_t acc;
    pdm_acc_t sum;

    // Flip the sign bit
    // -32768 maps to 0, +32767 maps to 65535
    assign offset = {~sample[sample_width-1], sample[sample_width-2:0]};

    // First-order loop
    // Only the lower 16 bits feed back, the carry is the output bit
    assign sum = {1'b0, acc[sample_width-1:0]} + {1'b0, offset};

    // Update only on the DAC strobe
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            acc <= '0;
        end else if (clk_en) begin
            acc <= sum;
        end
    end

    // Registered carry, holds between updates
    // Density of ones tracks offset/65536
    assign sound_int = acc[sample_width];

endmodule

`default_nettype wire

// File: src/dac_clock_divider.sv
`default_nettype none

module dac_clock_divider #(
    parameter int div = 2
) (
    input  logic DAC_BCLK_SRC,
    input  logic RESET_n,
    output logic tick,
    output logic clk_out
);

    // Counter wide enough for div-1, at least one bit
    localparam int cnt_width = (div > 1) ? $clog2(div) : 1;
    localparam logic [cnt_width-1:0] reload = cnt_width'(div - 1);

    logic [cnt_width-1:0] cnt;

    // One-cycle strobe on terminal count
    assign tick = (cnt == '0);

    // Down-counter, reloads after reaching zero
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt <= reload;
        end else if (tick) begin
            cnt <= reload;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // Toggle at the end of each tick cycle
    // Gives a 50% duty level with period 2*div
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            clk_out <= 1'b0;
        end else if (tick) begin
            clk_out <= ~clk_out;
        end
    end

endmodule

`default_nettype wire

// File: src/dac_i2s.sv
`default_nettype none

module dac_i2s
    import sound_pkg::*;
(
    input  logic    DAC_BCLK_SRC,
    input  logic    RESET_n,
    input  logic    bclk,
    input  logic    bclk_tick,
    input  sample_t sample_left,
    input  sample_t sample_right,
    output logic    lrclk,
    output logic    din
);

    // One slot per sample bit
    localparam int cnt_width = $clog2(sample_width);
    localparam logic [cnt_width-1:0] last_slot = cnt_width'(sample_width - 1);

    i2s_state_t state;

    // Current slot within the channel
    logic [cnt_width-1:0] bit_cnt;

    // Outgoing word, MSB first
    logic [sample_width-1:0] shift_reg;

    // Right word held from frame start
    sample_t right_word;

    logic fall_tick;
    logic slot_end;
    logic load_left;
    logic load_right;

    // Tick while bclk high means bclk falls on this edge
    assign fall_tick = bclk_tick & bclk;

    // Last slot of the current channel
    assign slot_end = (bit_cnt == last_slot);

    // Frame start: first tick out of idle or end of right channel
    assign load_left = (state == i2s_idle) ||
                       ((state == i2s_right) && slot_end);

    // Right channel start
    assign load_right = (state == i2s_left) && slot_end;

    // Channel FSM, slot counter and word select
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            state   <= i2s_idle;
            bit_cnt <= '0;
            lrclk   <= 1'b0;
        end else if (fall_tick) begin
            bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
            case (state)
                i2s_idle: begin
                    // First falling edge opens the left slot
                    state   <= i2s_left;
                    bit_cnt <= '0;
                    lrclk   <= 1'b0;
                end
                i2s_left: begin
                    if (slot_end) begin
                        state <= i2s_right;
                        lrclk <= 1'b1;
                    end
                end
                i2s_right: begin
                    if (slot_end) begin
                        state <= i2s_left;
                        lrclk <= 1'b0;
                    end
                end
                default: begin
                    // Unused encoding, restart on a left slot
                    state   <= i2s_left;
                    bit_cnt <= '0;
                    lrclk   <= 1'b0;
                end
            endcase
        end
    end

    // Word loading and shifting
    // At a channel start the old LSB is still in the top bit
    always_ff @(posedge DAC_BCLK_SRC) begin
        if (fall_tick) begin
            if (load_left) begin
                // Both channels sampled once per frame
                shift_reg  <= sample_left;
                right_word <= sample_right;
            end else if (load_right) begin
                shift_reg <= right_word;
            end else begin
                shift_reg <= {shift_reg[sample_width-2:0], 1'b0};
            end
        end
    end

    // Serial data out
    // One-slot delay after lrclk comes from the previous LSB
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            din <= 1'b0;
        end else if (fall_tick) begin
            // Nothing sent before the first frame
            din <= (state == i2s_idle) ? 1'b0 : shift_reg[sample_width-1];
        end
    end

endmodule

`default_nettype wire

// File: src/sound_out_top.sv
`default_nettype none

module sound_out_top
    import sound_pkg::*;
#(
    parameter int sclk_div = default_sclk_div,
    parameter int bclk_div = default_bclk_div,
    parameter int dac_div  = default_dac_div
) (
    input  logic    DAC_BCLK_SRC,
    input  logic    RESET_n,
    input  sample_t sample_int,
    input  sample_t sample_left,
    input  sample_t sample_right,
    output logic    sound_int,
    output logic    i2s_sclk,
    output logic    i2s_bclk,
    output logic    i2s_lrclk,
    output logic    i2s_din
);

    // Bit clock strobe, one cycle per bclk half period
    logic bclk_tick;

    // Update strobe for the internal 1-bit DAC
    logic dac_en;

    // DAC master clock for the external part
    // Only the pin level is needed
    dac_clock_divider #(
        .div        (sclk_div)
    ) sclk_div_inst (
        .DAC_BCLK_SRC,
        .RESET_n,
        .tick       (),
        .clk_out    (i2s_sclk)
    );

    // I2S bit clock
    // Pin level plus the strobe that paces the serializer
    dac_clock_divider #(
        .div        (bclk_div)
    ) bclk_div_inst (
        .DAC_BCLK_SRC,
        .RESET_n,
        .tick       (bclk_tick),
        .clk_out    (i2s_bclk)
    );

    // Internal DAC update rate
    // Strobe only, no pin
    dac_clock_divider #(
        .div        (dac_div)
    ) dac_div_inst (
        .DAC_BCLK_SRC,
        .RESET_n,
        .tick       (dac_en),
        .clk_out    ()
    );

    // Cartridge sound pin
    dac_1bit dac_1bit_inst (
        .DAC_BCLK_SRC,
        .RESET_n,
        .clk_en     (dac_en),
        .sample     (sample_int),
        .sound_int
    );

    // External stereo DAC
    dac_i2s dac_i2s_inst (
        .DAC_BCLK_SRC,
        .RESET_n,
        .bclk       (i2s_bclk),
        .bclk_tick,
        .sample_left,
        .sample_right,
        .lrclk      (i2s_lrclk),
        .din        (i2s_din)
    );

endmodule

`default_nettype wire

// File: src/sound_pkg.sv
`default_nettype none

package sound_pkg;

    // Audio sample width in bits
    localparam int sample_width = 16;

    // Signed PCM sample, two's complement
    typedef logic signed [sample_width-1:0] sample_t;

    // Delta-sigma accumulator
    // Top bit is the carry out of the 16-bit add
    typedef logic [sample_width:0] pdm_acc_t;

    // Serializer channel state
    typedef enum logic [1:0] {
        i2s_idle,
        i2s_left,
        i2s_right
    } i2s_state_t;

    // Default divisors
    // DAC master clock, half-rate toggle
    localparam int default_sclk_div = 19;
    // I2S bit clock, half-rate toggle
    localparam int default_bclk_div = 38;
    // 1-bit DAC update strobe
    localparam int default_dac_div = 5;

endpackage

`default_nettype wire

// File: verification/dac_i2s_assertions.sv
`default_nettype none

module dac_i2s_assertions
    import sound_pkg::*;
(
    input logic       DAC_BCLK_SRC,
    input logic       RESET_n,
    input logic       bclk,
    input logic       bclk_tick,
    input logic       lrclk,
    input logic       din,
    input i2s_state_t state
);

    // Failure counts per property
    int lrclk_din_failures = 0;
    int idle_failures = 0;
    int din_hold_failures = 0;

    // Pins move only on the edge after a tick with bclk high
    // That edge is the bclk falling edge
    property pins_on_fall_tick;
        @(posedge DAC_BCLK_SRC) disable iff (!RESET_n)
        !$past(bclk_tick && bclk) |-> ($stable(lrclk) && $stable(din));
    endproperty

    // Once out of idle the FSM stays in the channel loop
    property no_return_to_idle;
        @(posedge DAC_BCLK_SRC) disable iff (!RESET_n)
        (state != i2s_idle) |=> (state != i2s_idle);
    endproperty

    // Receiver samples din while bclk is high
    property din_hold_bclk_high;
        @(posedge DAC_BCLK_SRC) disable iff (!RESET_n)
        (bclk && $past(bclk)) |-> $stable(din);
    endproperty

    pins_on_fall_tick_a: assert property (pins_on_fall_tick)
        else begin
            lrclk_din_failures++;
            $error("I2S lrclk or din changed without a falling bclk tick");
        end

    no_return_to_idle_a: assert property (no_return_to_idle)
        else begin
            idle_failures++;
            $error("I2S serializer went back to idle outside reset");
        end

    din_hold_bclk_high_a: assert property (din_hold_bclk_high)
        else begin
            din_hold_failures++;
            $error("I2S din changed while bclk was high");
        end

endmodule

`default_nettype wire

// File: verification/sound_out_tb.sv
`default_nettype none

module sound_out_tb
    import sound_pkg::*;
();

    // Small divisors keep frames short
    localparam int tb_sclk_div = 3;
    localparam int tb_bclk_div = 2;
    localparam int tb_dac_div  = 2;

    localparam int reset_cycles = 5;
    localparam int num_entries  = 8;

    // One I2S frame in clock cycles
    // Two channels of 16 bclk periods, each 2*bclk_div cycles long
    localparam int frame_cycles  = 2 * sample_width * 2 * tb_bclk_div;
    // Six decoded words cover three frames
    localparam int words_needed  = 6;
    localparam int frame_timeout = 8 * frame_cycles;

    logic    DAC_BCLK_SRC;
    logic    RESET_n;
    sample_t sample_int;
    sample_t sample_left;
    sample_t sample_right;
    logic    sound_int;
    logic    i2s_sclk;
    logic    i2s_bclk;
    logic    i2s_lrclk;
    logic    i2s_din;

    // Stimulus table, one row per entry
    sample_t tab_left  [num_entries];
    sample_t tab_right [num_entries];
    sample_t tab_int   [num_entries];
    // Rows that also get the long 1-bit DAC measurement
    bit      tab_pdm   [num_entries];

    int     error_count;
    int     timeout_count;
    int     assert_count;
    integer seed;

    sound_out_top #(
        .sclk_div     (tb_sclk_div),
        .bclk_div     (tb_bclk_div),
        .dac_div      (tb_dac_div)
    ) sound_out_top_inst (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .sample_int   (sample_int),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sound_int    (sound_int),
        .i2s_sclk     (i2s_sclk),
        .i2s_bclk     (i2s_bclk),
        .i2s_lrclk    (i2s_lrclk),
        .i2s_din      (i2s_din)
    );

    // Serializer checks, attached to every dac_i2s
    bind dac_i2s dac_i2s_assertions dac_i2s_assertions_inst (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .bclk         (bclk),
        .bclk_tick    (bclk_tick),
        .lrclk        (lrclk),
        .din          (din),
        .state        (state)
    );

    // 20 unit clock
    initial begin
        DAC_BCLK_SRC = 1'b0;
        forever #10 DAC_BCLK_SRC = ~DAC_BCLK_SRC;
    end

    task automatic check_value(input string name, input int expected, input int actual,
                               input int tol);
        if (actual > expected + tol || actual < expected - tol) begin
            error_count++;
            $display("mismatch at %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    // All five pins low
    task automatic check_outputs_low();
        check_value("sound_int", 0, int'(sound_int), 0);
        check_value("i2s_sclk", 0, int'(i2s_sclk), 0);
        check_value("i2s_bclk", 0, int'(i2s_bclk), 0);
        check_value("i2s_lrclk", 0, int'(i2s_lrclk), 0);
        check_value("i2s_din", 0, int'(i2s_din), 0);
    endtask

    task automatic set_entry(input int idx, input sample_t left, input sample_t right,
                             input sample_t int_val, input bit pdm);
        tab_left[idx]  = left;
        tab_right[idx] = right;
        tab_int[idx]   = int_val;
        tab_pdm[idx]   = pdm;
    endtask

    task automatic fill_table();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        int          n;
        // Corners: zero, full scale, alternating bits
        set_entry(0, 16'sh0000, 16'sh0000, 16'sh0000, 1'b1);
        set_entry(1, 16'sh7fff, 16'sh8000, 16'sh7fff, 1'b1);
        set_entry(2, 16'sh8000, 16'sh7fff, 16'sh8000, 1'b1);
        set_entry(3, 16'shaaaa, 16'sh5555, 16'sh5555, 1'b1);
        set_entry(4, 16'sh5555, 16'shaaaa, 16'shaaaa, 1'b0);
        // Seeded random rows, only the first gets the DAC window
        for (n = 5; n < num_entries; n++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            set_entry(n, rnd_a[15:0], rnd_a[31:16], rnd_b[15:0], n == 5);
        end
    endtask

    // Reset with the row's samples already on the inputs
    task automatic apply_reset(input int idx);
        int n;
        @(posedge DAC_BCLK_SRC);
        #2;
        RESET_n      = 1'b0;
        sample_left  = tab_left[idx];
        sample_right = tab_right[idx];
        sample_int   = tab_int[idx];
        for (n = 0; n < reset_cycles; n++) begin
            @(negedge DAC_BCLK_SRC);
            check_outputs_low();
            @(posedge DAC_BCLK_SRC);
        end
        #2;
        RESET_n = 1'b1;
    endtask

    // Pin-level I2S decoder and clock spacing monitor
    // Cycle k is the falling clock edge after rising edge k past release
    task automatic watch_frames(input int idx);
        int      cycle;
        int      words_done;
        int      changes;
        int      rises;
        int      last_bclk_edge;
        int      last_sclk_edge;
        logic    prev_bclk;
        logic    prev_sclk;
        logic    prev_lrclk;
        logic    word_pending;
        logic    word_chan;
        sample_t shift_word;
        cycle          = 0;
        words_done     = 0;
        changes        = 0;
        rises          = 0;
        last_bclk_edge = 0;
        last_sclk_edge = 0;
        prev_bclk      = 1'b0;
        prev_sclk      = 1'b0;
        prev_lrclk     = 1'b0;
        word_pending   = 1'b0;
        word_chan      = 1'b0;
        shift_word     = '0;
        while (words_done < words_needed && cycle < frame_timeout) begin
            @(negedge DAC_BCLK_SRC);
            // Release cycle and the one after it
            if (cycle < 2) begin
                check_outputs_low();
            end
            // Half period of each divided clock equals its divisor
            if (i2s_bclk != prev_bclk) begin
                check_value("i2s_bclk half period", tb_bclk_div, cycle - last_bclk_edge, 0);
                last_bclk_edge = cycle;
            end
            if (i2s_sclk != prev_sclk) begin
                check_value("i2s_sclk half period", tb_sclk_div, cycle - last_sclk_edge, 0);
                last_sclk_edge = cycle;
            end
            if (i2s_lrclk != prev_lrclk) begin
                if (changes == 0) begin
                    // One rise before the idle exit, then the full left slot
                    check_value("i2s_bclk rises before first lrclk change",
                                sample_width + 1, rises, 0);
                end else begin
                    check_value("i2s_bclk rises per slot", sample_width, rises, 0);
                end
                changes++;
                rises        = 0;
                word_pending = 1'b1;
                word_chan    = prev_lrclk;
            end
            if (i2s_bclk && !prev_bclk) begin
                shift_word = {shift_word[sample_width-2:0], i2s_din};
                rises++;
                // LSB lands on the first rise after the change
                if (word_pending) begin
                    word_pending = 1'b0;
                    words_done++;
                    // Words 3 and 4 are the second frame
                    if (words_done == 3) begin
                        check_value("i2s_lrclk of left word", 0, int'(word_chan), 0);
                        check_value("i2s_din left word", int'(tab_left[idx]),
                                    int'(shift_word), 0);
                    end
                    if (words_done == 4) begin
                        check_value("i2s_lrclk of right word", 1, int'(word_chan), 0);
                        check_value("i2s_din right word", int'(tab_right[idx]),
                                    int'(shift_word), 0);
                    end
                end
            end
            prev_bclk  = i2s_bclk;
            prev_sclk  = i2s_sclk;
            prev_lrclk = i2s_lrclk;
            cycle++;
        end
        if (words_done < words_needed) begin
            timeout_count++;
            $display("timeout: entry %0d gave only %0d of %0d I2S words in %0d cycles",
                     idx, words_done, words_needed, cycle);
        end
    endtask

    // Density of ones over 65536 updates
    task automatic count_sound_ones(input int idx);
        int cycle;
        int ones;
        int expected;
        ones = 0;
        // Offset binary is the sample plus half scale
        expected = int'(tab_int[idx]) + (1 << (sample_width - 1));
        for (cycle = 0; cycle < 65536 * tb_dac_div; cycle++) begin
            @(negedge DAC_BCLK_SRC);
            if (sound_int) begin
                ones++;
            end
        end
        check_value("sound_int ones per 65536 updates", expected, ones / tb_dac_div, 1);
    endtask

    initial begin
        int idx;
        RESET_n       = 1'b0;
        sample_int    = '0;
        sample_left   = '0;
        sample_right  = '0;
        error_count   = 0;
        timeout_count = 0;
        seed          = 32'h03a875bf;
        fill_table();
        for (idx = 0; idx < num_entries; idx++) begin
            apply_reset(idx);
            // Both measurements start at reset release
            fork
                watch_frames(idx);
                begin
                    if (tab_pdm[idx]) begin
                        count_sound_ones(idx);
                    end
                end
            join
        end
        assert_count =
            sound_out_top_inst.dac_i2s_inst.dac_i2s_assertions_inst.lrclk_din_failures +
            sound_out_top_inst.dac_i2s_inst.dac_i2s_assertions_inst.idle_failures +
            sound_out_top_inst.dac_i2s_inst.dac_i2s_assertions_inst.din_hold_failures;
        $display("checks finished: %0d mismatches, %0d timeouts, %0d assertion failures",
                 error_count, timeout_count, assert_count);
        if (error_count == 0 && timeout_count == 0 && assert_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
